/* build.f */
source/qsim_pkg.sv
source/pass_ctrl_if.sv
source/elem_tag_if.sv
source/qsim_controller.sv
source/qsim_addr_gen.sv
source/cmac_unit.sv
source/qsim_writeback.sv
source/qsim_top.sv
+incdir+test
test/tb_qsim.sv

/* source/cmac_unit.sv */
`timescale 1ns/1ps

module cmac_unit
  import qsim_pkg::*;
(
  input  logic           clk,
  input  logic           reset_n,
  elem_tag_if.mac        tag,
  input  cplx_t          input_read_data,
  input  cplx_t          scratch_read_data,
  input  cplx_t          gates_read_data,
  output cplx_t          row_sum
);

  // tag delayed to meet the sram read data
  logic  valid_d1;
  logic  first_d1;
  logic  from_input_d1;
  logic  valid_s1;
  logic  first_s1;
  logic  valid_s2;
  logic  first_s2;
  cplx_t state_op;
  comp_t s_re;
  comp_t s_im;
  comp_t g_re;
  comp_t g_im;
  comp_t p_rr;
  comp_t p_ii;
  comp_t p_ri;
  comp_t p_ir;
  comp_t sum_re;
  comp_t sum_im;
  comp_t acc_re;
  comp_t acc_im;

  // full product, shift out the fraction, keep low 16 bits
  function automatic comp_t fx_mul(input comp_t a, input comp_t b);
    logic signed [2*COMP_W-1:0] prod;
    prod = a * b;
    return comp_t'(prod >>> FRAC_BITS);
  endfunction

  // operand select
  assign state_op = from_input_d1 ? input_read_data : scratch_read_data;
  assign s_re = state_op[2*COMP_W-1:COMP_W];
  assign s_im = state_op[COMP_W-1:0];
  assign g_re = gates_read_data[2*COMP_W-1:COMP_W];
  assign g_im = gates_read_data[COMP_W-1:0];

  // --------------------
  // tag pipe
  // --------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      valid_d1      <= 1'b0;
      first_d1      <= 1'b0;
      from_input_d1 <= 1'b0;
      valid_s1      <= 1'b0;
      first_s1      <= 1'b0;
      valid_s2      <= 1'b0;
      first_s2      <= 1'b0;
    end else begin
      valid_d1      <= tag.valid;
      first_d1      <= tag.first_col;
      from_input_d1 <= tag.from_input;
      valid_s1      <= valid_d1;
      first_s1      <= first_d1;
      valid_s2      <= valid_s1;
      first_s2      <= first_s1;
    end
  end

  // --------------------
  // arithmetic stages
  // --------------------
  always_ff @(posedge clk) begin
    // stage 1, four partial products
    p_rr <= fx_mul(g_re, s_re);
    p_ii <= fx_mul(g_im, s_im);
    p_ri <= fx_mul(g_re, s_im);
    p_ir <= fx_mul(g_im, s_re);
    // stage 2, complex combine, wraps at 16 bits
    sum_re <= p_rr - p_ii;
    sum_im <= p_ri + p_ir;
    // stage 3, row accumulate, restarts on column 0
    if (valid_s2) begin
      if (first_s2) begin
        acc_re <= sum_re;
        acc_im <= sum_im;
      end else begin
        acc_re <= acc_re + sum_re;
        acc_im <= acc_im + sum_im;
      end
    end
  end

  assign row_sum = {acc_re, acc_im};

endmodule

/* source/elem_tag_if.sv */
`timescale 1ns/1ps

// per element tags, aligned with the read addresses they describe
interface elem_tag_if
  import qsim_pkg::*;
();
  logic      valid;
  logic      first_col;
  logic      last_col;
  elem_idx_t row;
  // state operand comes from the input sram
  logic      from_input;

  modport src (
    output valid, first_col, last_col, row, from_input
  );
  modport mac (
    input valid, first_col, from_input
  );
  modport wb (
    input valid, last_col, row
  );
endinterface

/* source/pass_ctrl_if.sv */
`timescale 1ns/1ps

// run and pass control between the FSM and the datapath blocks
interface pass_ctrl_if
  import qsim_pkg::*;
();
  // header capture, num_qubits only meaningful with header_load
  logic         header_load;
  qubit_count_t num_qubits;
  // pass sequencing
  logic start_pass;
  logic to_scratch;
  logic sweep_done;
  logic pass_written;

  modport ctrl (
    output header_load, num_qubits, start_pass, to_scratch,
    input  sweep_done, pass_written
  );
  modport addr (
    input  header_load, num_qubits, start_pass, to_scratch,
    output sweep_done
  );
  modport wb (
    input  to_scratch, sweep_done,
    output pass_written
  );
endinterface

/* source/qsim_addr_gen.sv */
`timescale 1ns/1ps

module qsim_addr_gen
  import qsim_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  pass_ctrl_if.addr  pass_ctrl,
  elem_tag_if.src    tag,
  output sram_addr_t input_read_address,
  output sram_addr_t scratch_read_address,
  output sram_addr_t gates_read_address
);

  qubit_count_t q;
  // set after the first pass of a run
  logic         base_used;
  sram_addr_t   gate_base;
  sram_addr_t   nxt_base;
  sram_addr_t   gate_size;
  elem_idx_t    col;
  elem_idx_t    col_max;
  elem_idx_t    nxt_row;
  elem_idx_t    nxt_col;
  logic         nxt_active;
  logic         last_elem;

  // 2^Q - 1 and 4^Q
  assign col_max   = elem_idx_t'((5'd1 << q) - 5'd1);
  assign gate_size = sram_addr_t'(1) << {q, 1'b0};
  assign last_elem = (tag.row == col_max) && (col == col_max);

  // each later pass moves to the next gate matrix
  assign nxt_base = (pass_ctrl.start_pass && base_used) ? gate_base + gate_size : gate_base;

  // --------------------
  // gate offset
  // --------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      q         <= '0;
      base_used <= 1'b0;
      gate_base <= '0;
    end else if (pass_ctrl.header_load) begin
      q         <= pass_ctrl.num_qubits;
      base_used <= 1'b0;
      gate_base <= '0;
    end else if (pass_ctrl.start_pass) begin
      base_used <= 1'b1;
      gate_base <= nxt_base;
    end
  end

  // --------------------
  // row and column sweep
  // --------------------
  always_comb begin
    nxt_active = tag.valid;
    nxt_row    = tag.row;
    nxt_col    = col;
    if (pass_ctrl.start_pass) begin
      nxt_active = 1'b1;
      nxt_row    = '0;
      nxt_col    = '0;
    end else if (tag.valid) begin
      if (last_elem) begin
        nxt_active = 1'b0;
      end else if (col == col_max) begin
        // row-major, wrap into next row
        nxt_col = '0;
        nxt_row = tag.row + 1'b1;
      end else begin
        nxt_col = col + 1'b1;
      end
    end
  end

  // addresses and tags registered together
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      tag.valid            <= 1'b0;
      tag.row              <= '0;
      tag.first_col        <= 1'b0;
      tag.last_col         <= 1'b0;
      tag.from_input       <= 1'b0;
      col                  <= '0;
      pass_ctrl.sweep_done <= 1'b0;
      input_read_address   <= '0;
      scratch_read_address <= '0;
      gates_read_address   <= '0;
    end else begin
      tag.valid            <= nxt_active;
      tag.row              <= nxt_row;
      tag.first_col        <= nxt_active && (nxt_col == '0);
      tag.last_col         <= nxt_active && (nxt_col == col_max);
      // even passes write the scratchpad and read the input sram
      tag.from_input       <= pass_ctrl.to_scratch;
      col                  <= nxt_col;
      // cycle after the last element went out
      pass_ctrl.sweep_done <= tag.valid && last_elem;
      if (nxt_active) begin
        input_read_address   <= sram_addr_t'(nxt_col) + sram_addr_t'(STATE_BASE);
        scratch_read_address <= sram_addr_t'(nxt_col);
        gates_read_address   <= nxt_base + (sram_addr_t'(nxt_row) << q) + sram_addr_t'(nxt_col);
      end else begin
        // idle reads point at the header word
        input_read_address   <= '0;
        scratch_read_address <= '0;
        gates_read_address   <= '0;
      end
    end
  end

  // column stays inside the matrix for the latched Q
  assert property (@(posedge clk) disable iff (!reset_n)
    tag.valid |-> (col <= col_max));

endmodule

/* source/qsim_controller.sv */
`timescale 1ns/1ps

module qsim_controller
  import qsim_pkg::*;
(
  input  logic      clk,
  input  logic      reset_n,
  input  logic      dut_valid,
  output logic      dut_ready,
  input  cplx_t     header_data,
  pass_ctrl_if.ctrl pass_ctrl
);

  ctrl_state_t state;
  ctrl_state_t nxt_state;
  // passes still to run, counts down per pass_written
  gate_count_t gates_left;
  gate_count_t header_gates;
  logic        pass_end;

  // --------------------
  // header fields
  // --------------------

  // Q upper half, M lower half
  assign header_gates = header_data[COMP_W-1:0];
  assign pass_ctrl.num_qubits = header_data[COMP_W +: $bits(qubit_count_t)];

  // addr gen parks the input read at 0 outside a sweep
  assign pass_ctrl.header_load = (state == load_header);
  // one cycle state, so a single pulse
  assign pass_ctrl.start_pass = (state == next_pass);

  // last row sum of the pass has landed
  assign pass_end = (state == drain) && pass_ctrl.pass_written;

  // --------------------
  // next state
  // --------------------
  always_comb begin
    nxt_state = state;
    case (state)
      idle: begin
        if (dut_valid && dut_ready) begin
          nxt_state = load_header;
        end
      end
      load_header: begin
        // no gates, nothing to write
        nxt_state = (header_gates == '0) ? idle : next_pass;
      end
      next_pass: begin
        nxt_state = calculate;
      end
      calculate: begin
        if (pass_ctrl.sweep_done) begin
          nxt_state = drain;
        end
      end
      drain: begin
        // wait for the pipe to empty before the buffers swap
        if (pass_ctrl.pass_written) begin
          nxt_state = (gates_left == gate_count_t'(1)) ? idle : next_pass;
        end
      end
      default: begin
        nxt_state = idle;
      end
    endcase
  end

  // --------------------
  // state and counters
  // --------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state                <= idle;
      dut_ready            <= 1'b0;
      gates_left           <= '0;
      pass_ctrl.to_scratch <= 1'b1;
    end else begin
      state     <= nxt_state;
      // registered, so high exactly while in idle
      dut_ready <= (nxt_state == idle);
      if (pass_ctrl.header_load) begin
        gates_left           <= header_gates;
        // pass 0 is even, writes the scratchpad
        pass_ctrl.to_scratch <= 1'b1;
      end else if (pass_end) begin
        gates_left           <= gates_left - 1'b1;
        pass_ctrl.to_scratch <= !pass_ctrl.to_scratch;
      end
    end
  end

  // header must name a supported register size
  assert property (@(posedge clk) disable iff (!reset_n)
    pass_ctrl.header_load |-> (pass_ctrl.num_qubits >= 1 &&
                               pass_ctrl.num_qubits <= MAX_QUBITS));

  // a pass only starts while a gate is still left to apply
  assert property (@(posedge clk) disable iff (!reset_n)
    pass_ctrl.start_pass |-> (gates_left != '0));

endmodule

/* source/qsim_pkg.sv */
package qsim_pkg;

  // --------------------
  // sizes
  // --------------------

  // largest supported register
  localparam int MAX_QUBITS  = 4;
  // fixed point format, one part
  localparam int COMP_W      = 16;
  localparam int FRAC_BITS   = 8;
  // sram addressing
  localparam int ADDR_W      = 16;
  // header word at 0, state vector right after
  localparam int STATE_BASE  = 1;
  // multiply, combine, accumulate
  localparam int MAC_LATENCY = 3;

  // --------------------
  // vector types
  // --------------------

  // one signed real or imag part
  typedef logic signed [COMP_W-1:0] comp_t;
  // {real, imag}, also the sram data word
  typedef logic [2*COMP_W-1:0] cplx_t;
  typedef logic [ADDR_W-1:0] sram_addr_t;
  // row or column of a gate matrix
  typedef logic [MAX_QUBITS-1:0] elem_idx_t;
  typedef logic [2:0] qubit_count_t;
  typedef logic [15:0] gate_count_t;

  // run FSM
  typedef enum logic [2:0] {
    idle,
    load_header,
    calculate,
    drain,
    next_pass
  } ctrl_state_t;

endpackage

/* source/qsim_top.sv */
`timescale 1ns/1ps

module qsim_top
  import qsim_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       dut_valid,
  output logic       dut_ready,
  // input state sram
  output sram_addr_t input_sram_read_address,
  input  cplx_t      input_sram_read_data,
  output logic       input_sram_write_enable,
  output sram_addr_t input_sram_write_address,
  output cplx_t      input_sram_write_data,
  // scratchpad sram
  output sram_addr_t scratch_sram_read_address,
  input  cplx_t      scratch_sram_read_data,
  output logic       scratch_sram_write_enable,
  output sram_addr_t scratch_sram_write_address,
  output cplx_t      scratch_sram_write_data,
  // output state sram, write only
  output logic       output_sram_write_enable,
  output sram_addr_t output_sram_write_address,
  output cplx_t      output_sram_write_data,
  // gates sram, read only
  output sram_addr_t gates_sram_read_address,
  input  cplx_t      gates_sram_read_data
);

  pass_ctrl_if pass_bus ();
  elem_tag_if  tag_bus ();

  cplx_t      row_sum;
  sram_addr_t dest_write_address;

  // one row sum feeds every destination
  assign input_sram_write_data      = row_sum;
  assign scratch_sram_write_data    = row_sum;
  assign output_sram_write_data     = row_sum;
  // enables pick the buffer, address shared
  assign input_sram_write_address   = dest_write_address;
  assign scratch_sram_write_address = dest_write_address;

  // --------------------
  // instances
  // --------------------
  qsim_controller controller_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .dut_valid   (dut_valid),
    .dut_ready   (dut_ready),
    .header_data (input_sram_read_data),
    .pass_ctrl   (pass_bus.ctrl)
  );

  qsim_addr_gen addr_gen_i (
    .clk                  (clk),
    .reset_n              (reset_n),
    .pass_ctrl            (pass_bus.addr),
    .tag                  (tag_bus.src),
    .input_read_address   (input_sram_read_address),
    .scratch_read_address (scratch_sram_read_address),
    .gates_read_address   (gates_sram_read_address)
  );

  cmac_unit cmac_i (
    .clk               (clk),
    .reset_n           (reset_n),
    .tag               (tag_bus.mac),
    .input_read_data   (input_sram_read_data),
    .scratch_read_data (scratch_sram_read_data),
    .gates_read_data   (gates_sram_read_data),
    .row_sum           (row_sum)
  );

  qsim_writeback writeback_i (
    .clk                  (clk),
    .reset_n              (reset_n),
    .tag                  (tag_bus.wb),
    .pass_ctrl            (pass_bus.wb),
    .input_write_enable   (input_sram_write_enable),
    .scratch_write_enable (scratch_sram_write_enable),
    .output_write_enable  (output_sram_write_enable),
    .dest_write_address   (dest_write_address),
    .output_write_address (output_sram_write_address)
  );

endmodule

/* source/qsim_writeback.sv */
`timescale 1ns/1ps

module qsim_writeback
  import qsim_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  elem_tag_if.wb     tag,
  pass_ctrl_if.wb    pass_ctrl,
  output logic       input_write_enable,
  output logic       scratch_write_enable,
  output logic       output_write_enable,
  output sram_addr_t dest_write_address,
  output sram_addr_t output_write_address
);

  // MAC_LATENCY stages here plus the output register
  logic [MAC_LATENCY-1:0] valid_pipe;
  logic [MAC_LATENCY-1:0] last_pipe;
  logic [MAC_LATENCY-1:0] done_pipe;
  elem_idx_t              row_pipe [MAC_LATENCY];
  logic                   row_hit;

  // row sum complete on its last column
  assign row_hit = valid_pipe[MAC_LATENCY-1] && last_pipe[MAC_LATENCY-1];

  // --------------------
  // enables
  // --------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      valid_pipe             <= '0;
      last_pipe              <= '0;
      done_pipe              <= '0;
      input_write_enable     <= 1'b0;
      scratch_write_enable   <= 1'b0;
      output_write_enable    <= 1'b0;
      pass_ctrl.pass_written <= 1'b0;
    end else begin
      valid_pipe           <= {valid_pipe[MAC_LATENCY-2:0], tag.valid};
      last_pipe            <= {last_pipe[MAC_LATENCY-2:0], tag.last_col};
      // sweep_done trails the last element by one, so it lands after the last write
      done_pipe            <= {done_pipe[MAC_LATENCY-2:0], pass_ctrl.sweep_done};
      input_write_enable   <= row_hit && !pass_ctrl.to_scratch;
      scratch_write_enable <= row_hit && pass_ctrl.to_scratch;
      // every pass also lands in the output sram
      output_write_enable  <= row_hit;
      pass_ctrl.pass_written <= done_pipe[MAC_LATENCY-1];
    end
  end

  // --------------------
  // addresses
  // --------------------
  always_ff @(posedge clk) begin
    row_pipe[0] <= tag.row;
    for (int i = 1; i < MAC_LATENCY; i++) begin
      row_pipe[i] <= row_pipe[i-1];
    end
    output_write_address <= sram_addr_t'(row_pipe[MAC_LATENCY-1]);
    // input sram keeps the header at 0
    if (pass_ctrl.to_scratch) begin
      dest_write_address <= sram_addr_t'(row_pipe[MAC_LATENCY-1]);
    end else begin
      dest_write_address <= sram_addr_t'(row_pipe[MAC_LATENCY-1]) + sram_addr_t'(STATE_BASE);
    end
  end

  // one destination buffer per pass, parity only moves with the pipe empty
  assert property (@(posedge clk) disable iff (!reset_n)
    !$stable(pass_ctrl.to_scratch) |-> (valid_pipe == '0));

  // sweep end and tag stream agree, pass_written right after a row write
  assert property (@(posedge clk) disable iff (!reset_n)
    pass_ctrl.pass_written |-> $past(output_write_enable));

endmodule

/* test/qsim_trace.txt */
// word 0 is the test count, then per test: header {Q,M}, initial state (2^Q),
// M gate matrices row-major (4^Q each), expected final state (2^Q)
00000006
// test 1, one qubit, X gate
00010001
01000000 00800040
00000000 01000000 01000000 00000000
00800040 01000000
// test 2, two qubits, two gates
00020002
01000000 00000100 00800080 FF000000
00000100 00000000 00000000 00000000 00000000 00800000 00000000 00000000
00000000 00000000 01000000 00000000 00000000 00000000 00000000 00800080
00800000 00800000 00000000 00000000 00800000 FF800000 00000000 00000000
00000000 00000000 00000000 01000000 00000000 00000000 01000000 00000000
000000C0 00000040 FF80FF80 00800080
// test 3, three qubits, shift then half then reverse
00030003
00100000 00200001 00300002 00400003 00500004 00600005 00700006 00800007
00000000 01000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 01000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 01000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 01000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 01000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 01000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 01000000
01000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00800000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00800000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00800000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00800000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00800000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00800000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00800000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00800000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 01000000
00000000 00000000 00000000 00000000 00000000 00000000 01000000 00000000
00000000 00000000 00000000 00000000 00000000 01000000 00000000 00000000
00000000 00000000 00000000 00000000 01000000 00000000 00000000 00000000
00000000 00000000 00000000 01000000 00000000 00000000 00000000 00000000
00000000 00000000 01000000 00000000 00000000 00000000 00000000 00000000
00000000 01000000 00000000 00000000 00000000 00000000 00000000 00000000
01000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00080000 00400003 00380003 00300002 00280002 00200001 00180001 00100000
// test 4, no gates
00020000
01000000 00000100 00800080 FF000000
01000000 00000100 00800080 FF000000
// test 5, four qubits, diagonal 2.0 and -1.0 with wrapping
00040001
4000FF00 4001FF01 4002FF02 4003FF03 4004FF04 4005FF05 4006FF06 4007FF07
4008FF08 4009FF09 400AFF0A 400BFF0B 400CFF0C 400DFF0D 400EFF0E 400FFF0F
02000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 FF000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 02000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 FF000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 02000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 FF000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 02000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 FF000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 02000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 FF000000 00000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 02000000 00000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 FF000000 00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 02000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 FF000000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 02000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000 FF000000
8000FE00 BFFF00FF 8004FE04 BFFD00FD 8008FE08 BFFB00FB 800CFE0C BFF900F9
8010FE10 BFF700F7 8014FE14 BFF500F5 8018FE18 BFF300F3 801CFE1C BFF100F1
// test 6, fresh run after test 5, phase then X
00010002
01000000 00000080
00000100 00000000 00000000 01000000
00000000 01000000 01000000 00000000
00000080 00000100

/* test/tb_qsim_checks.svh */
`ifndef TB_QSIM_CHECKS_SVH
`define TB_QSIM_CHECKS_SVH

// --------------------
// counters
// --------------------
int error_count = 0;
int check_count = 0;
int test_count  = 0;

// one complex data word against its expected value
task automatic check_cplx(input string name, input cplx_t actual, input cplx_t expected);
  check_count++;
  if (actual !== expected) begin
    error_count++;
    $display("FAIL %s actual=%08h expected=%08h", name, actual, expected);
  end
endtask

// address sized counts, e.g. number of output writes
task automatic check_addr(input string name, input sram_addr_t actual,
                          input sram_addr_t expected);
  check_count++;
  if (actual !== expected) begin
    error_count++;
    $display("FAIL %s actual=%04h expected=%04h", name, actual, expected);
  end
endtask

// a failure that is not a value mismatch
task automatic report_problem(input string what);
  error_count++;
  $display("problem: %s", what);
endtask

// --------------------
// report lines
// --------------------

// errs_before is the error count when the test began
task automatic report_test(input int idx, input int q, input int m, input int errs_before);
  int errs;
  errs = error_count - errs_before;
  test_count++;
  if (errs == 0) begin
    $display("test %0d: Q=%0d M=%0d ok", idx, q, m);
  end else begin
    $display("test %0d: Q=%0d M=%0d %0d mismatches", idx, q, m, errs);
  end
endtask

// closing summary, counts only
task automatic report_summary();
  $display("tests run: %0d, checks: %0d, failures: %0d",
           test_count, check_count, error_count);
endtask

`endif

/* test/tb_qsim.sv */
`timescale 1ns/1ps

module tb_qsim
  import qsim_pkg::*;
();

  localparam int TRACE_WORDS = 1024;
  localparam int MEM_WORDS   = 1024;

  logic       clk = 1'b0;
  logic       reset_n;
  logic       dut_valid;
  logic       dut_ready;
  sram_addr_t in_ra, in_wa, sc_ra, sc_wa, out_wa, gt_ra;
  cplx_t      in_rd, in_wd, sc_rd, sc_wd, out_wd, gt_rd;
  logic       in_we, sc_we, out_we;

  // behavioral srams
  cplx_t input_mem   [MEM_WORDS];
  cplx_t scratch_mem [MEM_WORDS];
  cplx_t output_mem  [MEM_WORDS];
  cplx_t gates_mem   [MEM_WORDS];
  cplx_t trace       [TRACE_WORDS];

  // running totals, tests look at differences
  int unsigned out_write_total = 0;
  int unsigned any_write_total = 0;
  int unsigned watch_cycles    = 0;

  `include "tb_qsim_checks.svh"

  qsim_top dut_i (
    .clk(clk), .reset_n(reset_n), .dut_valid(dut_valid), .dut_ready(dut_ready),
    .input_sram_read_address(in_ra), .input_sram_read_data(in_rd),
    .input_sram_write_enable(in_we), .input_sram_write_address(in_wa),
    .input_sram_write_data(in_wd),
    .scratch_sram_read_address(sc_ra), .scratch_sram_read_data(sc_rd),
    .scratch_sram_write_enable(sc_we), .scratch_sram_write_address(sc_wa),
    .scratch_sram_write_data(sc_wd),
    .output_sram_write_enable(out_we), .output_sram_write_address(out_wa),
    .output_sram_write_data(out_wd),
    .gates_sram_read_address(gt_ra), .gates_sram_read_data(gt_rd)
  );

  always #20 clk = !clk;

  // --------------------
  // sram models
  // --------------------
  // address seen in cycle t, data driven just after the next edge
  always @(posedge clk) begin
    sram_addr_t a_in, a_sc, a_gt;
    a_in = in_ra;
    a_sc = sc_ra;
    a_gt = gt_ra;
    #2;
    in_rd = input_mem[a_in];
    sc_rd = scratch_mem[a_sc];
    gt_rd = gates_mem[a_gt];
  end

  always @(posedge clk) begin
    if (in_we) input_mem[in_wa] <= in_wd;
    if (sc_we) scratch_mem[sc_wa] <= sc_wd;
    if (out_we) begin
      output_mem[out_wa] <= out_wd;
      out_write_total++;
    end
    if (in_we || sc_we || out_we) any_write_total++;
  end

  // tag in the top byte, whole address below
  function automatic cplx_t fill_word(input int tag, input int addr);
    return {tag[7:0], 8'h5a, addr[15:0]};
  endfunction

  // step to 2 ns after the next rising edge
  task automatic wait_cycle();
    @(posedge clk);
    #2;
  endtask

  // valid while ready, then wait for ready to come back
  task automatic start_run();
    while (!dut_ready) wait_cycle();
    dut_valid = 1'b1;
    wait_cycle();
    dut_valid = 1'b0;
    while (!dut_ready) wait_cycle();
  endtask

  // --------------------
  // watchdog
  // --------------------
  initial begin
    wait (watch_cycles != 0);
    repeat (watch_cycles) @(posedge clk);
    $display("watchdog expired before all tests finished");
    $display("Errors found");
    $finish;
  end

  // --------------------
  // test loop
  // --------------------
  initial begin
    int ptr, n_tests, q, m, n, gsz, errs_before;
    int unsigned writes_before, any_before, budget;
    cplx_t hdr;
    reset_n   = 1'b0;
    dut_valid = 1'b0;
    in_rd = '0;
    sc_rd = '0;
    gt_rd = '0;
    for (int i = 0; i < TRACE_WORDS; i++) trace[i] = 'x;
    $readmemh("test/qsim_trace.txt", trace);
    // budget from the trace, (M+1)*(4^Q+8) per test
    n_tests = trace[0];
    ptr = 1;
    budget = 200 + 16;
    for (int t = 0; t < n_tests; t++) begin
      q = trace[ptr][31:16];
      m = trace[ptr][15:0];
      n = 1 << q;
      budget += (m + 1) * (n * n + 8);
      ptr += 1 + 2 * n + m * n * n;
    end
    watch_cycles = budget;
    if ($isunknown(trace[0])) begin
      report_problem("trace file could not be read");
      n_tests = 0;
    end
    repeat (16) @(posedge clk);
    #2;
    reset_n = 1'b1;
    ptr = 1;
    for (int t = 0; t < n_tests; t++) begin
      hdr = trace[ptr];
      q = hdr[31:16];
      m = hdr[15:0];
      n = 1 << q;
      gsz = n * n;
      errs_before = error_count;
      // fresh memories for every run
      for (int a = 0; a < MEM_WORDS; a++) begin
        input_mem[a]   = fill_word(8'h11, a);
        scratch_mem[a] = fill_word(8'h22, a);
        output_mem[a]  = fill_word(8'h33, a);
        gates_mem[a]   = fill_word(8'h44, a);
      end
      input_mem[0] = hdr;
      for (int r = 0; r < n; r++) input_mem[STATE_BASE + r] = trace[ptr + 1 + r];
      for (int g = 0; g < m * gsz; g++) gates_mem[g] = trace[ptr + 1 + n + g];
      ptr += 1 + n + m * gsz;
      // let the parked header read settle
      wait_cycle();
      wait_cycle();
      writes_before = out_write_total;
      any_before    = any_write_total;
      start_run();
      if (m == 0) begin
        check_addr("write enable count", sram_addr_t'(any_write_total - any_before), '0);
        for (int r = 0; r < n; r++) begin
          check_cplx($sformatf("input_mem[%0d]", STATE_BASE + r),
                     input_mem[STATE_BASE + r], trace[ptr + r]);
        end
      end else begin
        check_addr("output write count", sram_addr_t'(out_write_total - writes_before),
                   sram_addr_t'(m * n));
        for (int r = 0; r < n; r++) begin
          check_cplx($sformatf("output_mem[%0d]", r), output_mem[r], trace[ptr + r]);
          // odd gate count ends in the scratchpad
          if (m % 2 == 1) begin
            check_cplx($sformatf("scratch_mem[%0d]", r), scratch_mem[r], trace[ptr + r]);
          end else begin
            check_cplx($sformatf("input_mem[%0d]", STATE_BASE + r),
                       input_mem[STATE_BASE + r], trace[ptr + r]);
          end
        end
      end
      ptr += n;
      report_test(t + 1, q, m, errs_before);
    end
    report_summary();
    if (error_count == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
